/* common/histPkg.sv */
package histPkg;

    // timestamp and histogram widths
    localparam int SampleWidth = 12;            // timestamp code width
    localparam int BinWidth    = 4;             // coarse bin and fine offset width
    localparam int CountWidth  = 8;             // saturating bin counter width

    typedef logic [SampleWidth-1:0] sampleT;    // one timestamp code
    typedef logic [BinWidth-1:0]    binT;       // coarse bin or window offset
    typedef logic [CountWidth-1:0]  countT;     // one bin count

    // derived histogram geometry
    localparam int BinCount   = 2 ** BinWidth;          // bins per histogram
    localparam int BinShift   = SampleWidth - BinWidth; // codes per coarse bin, as a shift
    localparam int CodeTop    = 2 ** SampleWidth;       // size of the code range
    localparam int HalfWindow = 2 ** (BinWidth - 1);    // half the fine window
    localparam int WindowTop  = CodeTop - BinCount;     // highest legal window start

    localparam countT CountMax = '1;            // counters stick here

    // The lane loops clearMem -> coarsePass -> clearMem -> finePass -> reportWait.
    // Each clearMem visit sweeps the count memory before the next pass starts.
    typedef enum logic [1:0] {
        clearMem,                               // memory sweep
        coarsePass,                             // top bits of each code
        finePass,                               // full resolution around the peak
        reportWait                              // result held for the collector
    } laneStateT;

endpackage

/* hdl/sampleDistributor.sv */
`timescale 1ns/1ps

module sampleDistributor #(
    parameter int NumPixels = 4,
    parameter int InDepth   = 4,
    parameter int LaneDepth = 2,
    localparam int PixWidth  = (NumPixels > 1) ? $clog2(NumPixels) : 1,
    localparam int PtrWidth  = (InDepth > 1) ? $clog2(InDepth) : 1,
    localparam int CredWidth = $clog2(LaneDepth + 1)
) (
    input  logic                 clk,
    input  logic                 combin_res,
    input  logic                 inValid,
    input  logic [PixWidth-1:0]  inPixel,
    input  histPkg::sampleT      inSample,
    output logic                 inCredit,
    output logic [NumPixels-1:0] laneValid,
    output histPkg::sampleT      laneSample,
    input  logic [NumPixels-1:0] laneCredit
);

    import histPkg::*;

    logic [PixWidth-1:0]  pixMem [InDepth];     // target lane per entry
    sampleT               sampleMem [InDepth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic [PtrWidth:0]    fill;                 // entries held
    logic [CredWidth-1:0] laneCred [NumPixels]; // free slots per lane FIFO
    logic [PixWidth-1:0]  headPixel;
    logic                 pop;

    assign headPixel = pixMem[rdPtr];
    assign pop       = (fill != '0) && (laneCred[headPixel] != '0);

    // head goes out in the pop cycle, credit returned upstream at once
    assign inCredit   = pop;
    assign laneSample = sampleMem[rdPtr];

    always_comb begin
        laneValid = '0;
        if (pop) begin
            laneValid[headPixel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            pixMem[wrPtr]    <= inPixel;
            sampleMem[wrPtr] <= inSample;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrPtr <= '0;
            rdPtr <= '0;
            fill  <= '0;
        end else begin
            if (inValid) begin
                wrPtr <= (wrPtr == PtrWidth'(InDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(InDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (inValid && !pop) begin
                fill <= fill + 1'b1;
            end else if (!inValid && pop) begin
                fill <= fill - 1'b1;
            end
        end
    end

    // per-lane credits, a send and a returned credit in one cycle cancel
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int p = 0; p < NumPixels; p++) begin
                laneCred[p] <= CredWidth'(LaneDepth);
            end
        end else begin
            for (int p = 0; p < NumPixels; p++) begin
                if (laneValid[p] && !laneCredit[p]) begin
                    laneCred[p] <= laneCred[p] - 1'b1;
                end else if (!laneValid[p] && laneCredit[p]) begin
                    laneCred[p] <= laneCred[p] + 1'b1;
                end
            end
        end
    end

endmodule

/* histLane/histLane.sv */
`timescale 1ns/1ps

module histLane #(
    parameter int SamplesPerPass = 16,
    parameter int LaneDepth      = 2,
    localparam int PtrWidth  = (LaneDepth > 1) ? $clog2(LaneDepth) : 1,
    localparam int PassWidth = $clog2(SamplesPerPass + 1)
) (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            laneValid,
    input  histPkg::sampleT laneSample,
    output logic            laneCredit,
    output logic            resValid,
    output histPkg::binT    resCoarse,
    output histPkg::sampleT resFine,
    output histPkg::countT  resCount,
    input  logic            takeResult
);

    import histPkg::*;

    // input FIFO
    sampleT               fifoMem [LaneDepth];
    logic [PtrWidth-1:0]  wrPtr;
    logic [PtrWidth-1:0]  rdPtr;
    logic [PtrWidth:0]    fifoFill;
    sampleT               headSample;
    logic                 pop;

    // pass control
    laneStateT            state;
    logic                 fineNext;             // clearMem leads into the fine pass
    binT                  sweepAddr;
    logic [PassWidth-1:0] passCnt;              // samples popped this pass
    logic                 passFull;
    logic                 lastPop;

    // bin selection at pop time
    sampleT               winOffset;
    binT                  popAddr;
    logic                 popHit;

    // read-modify-write pipeline
    countT                binMem [BinCount];
    logic                 s1Hit;
    logic                 s1Last;
    binT                  s1Addr;
    countT                s1Old;
    countT                s1New;
    logic                 s2Hit;
    logic                 s2Last;
    binT                  s2Addr;
    countT                s2Count;

    // peak tracking and window
    countT                maxCount;
    binT                  maxBin;
    logic                 peakUpd;
    binT                  peakBinNow;
    binT                  coarseBin;
    sampleT               winStart;

    // fine window start from the coarse peak, clamped to the code range
    function automatic sampleT winStartOf(binT peak);
        logic [SampleWidth:0] code;
        code = {1'b0, peak, {BinShift{1'b0}}};
        if (code <= HalfWindow) begin
            return '0;
        end else if (code >= CodeTop - HalfWindow) begin
            return sampleT'(WindowTop);
        end
        return sampleT'(code - HalfWindow);
    endfunction

    assign headSample = fifoMem[rdPtr];
    assign passFull   = (passCnt == PassWidth'(SamplesPerPass));
    assign lastPop    = (passCnt == PassWidth'(SamplesPerPass - 1));
    assign pop        = (fifoFill != '0) && !passFull &&
                        (state == coarsePass || state == finePass);
    assign laneCredit = pop;

    always_ff @(posedge clk) begin
        if (laneValid) begin
            fifoMem[wrPtr] <= laneSample;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            wrPtr    <= '0;
            rdPtr    <= '0;
            fifoFill <= '0;
        end else begin
            if (laneValid) begin
                wrPtr <= (wrPtr == PtrWidth'(LaneDepth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == PtrWidth'(LaneDepth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (laneValid && !pop) begin
                fifoFill <= fifoFill + 1'b1;
            end else if (!laneValid && pop) begin
                fifoFill <= fifoFill - 1'b1;
            end
        end
    end

    // a code below the window start wraps to a large offset, so one check covers both ends
    always_comb begin
        winOffset = headSample - winStart;
        if (state == coarsePass) begin
            popAddr = headSample[SampleWidth-1 -: BinWidth];
            popHit  = 1'b1;
        end else begin
            popAddr = winOffset[BinWidth-1:0];
            popHit  = (winOffset[SampleWidth-1:BinWidth] == '0);
        end
    end

    always_comb begin
        s1Old = (s2Hit && s2Addr == s1Addr) ? s2Count : binMem[s1Addr]; // forward pending write
        s1New = (s1Old == CountMax) ? s1Old : s1Old + 1'b1;
    end

    assign peakUpd    = s2Hit && (s2Count > maxCount);  // strictly greater only
    assign peakBinNow = peakUpd ? s2Addr : maxBin;

    always_ff @(posedge clk) begin
        if (state == clearMem) begin
            binMem[sweepAddr] <= '0;
        end else if (s2Hit) begin
            binMem[s2Addr] <= s2Count;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr  <= popAddr;
        s2Addr  <= s1Addr;
        s2Count <= s1New;
        if (state == coarsePass && s2Last) begin
            coarseBin <= peakBinNow;
            winStart  <= winStartOf(peakBinNow);
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            s1Hit     <= 1'b0;
            s1Last    <= 1'b0;
            s2Hit     <= 1'b0;
            s2Last    <= 1'b0;
            state     <= clearMem;
            fineNext  <= 1'b0;
            sweepAddr <= '0;
            passCnt   <= '0;
            maxCount  <= '0;
            maxBin    <= '0;
            resValid  <= 1'b0;
        end else begin
            s1Hit  <= pop && popHit;    // out-of-window samples become bubbles
            s1Last <= pop && lastPop;
            s2Hit  <= s1Hit;
            s2Last <= s1Last;
            if (pop) begin
                passCnt <= passCnt + 1'b1;
            end
            if (peakUpd) begin
                maxCount <= s2Count;
                maxBin   <= s2Addr;
            end
            case (state)
                clearMem: begin
                    maxCount  <= '0;
                    maxBin    <= '0;
                    sweepAddr <= sweepAddr + 1'b1;  // wraps to 0 for the next sweep
                    if (sweepAddr == binT'(BinCount - 1)) begin
                        state   <= fineNext ? finePass : coarsePass;
                        passCnt <= '0;
                    end
                end
                coarsePass: begin
                    if (s2Last) begin
                        fineNext <= 1'b1;
                        state    <= clearMem;
                    end
                end
                finePass: begin
                    if (s2Last) begin
                        resValid <= 1'b1;   // three cycles after the last pop
                        state    <= reportWait;
                    end
                end
                reportWait: begin
                    if (takeResult) begin
                        resValid <= 1'b0;
                        fineNext <= 1'b0;
                        state    <= clearMem;
                    end
                end
                default: state <= clearMem;
            endcase
        end
    end

    assign resCoarse = coarseBin;
    assign resFine   = winStart + sampleT'(maxBin);     // absolute fine peak code
    assign resCount  = maxCount;

endmodule

/* hdl/resultCollector.sv */
`timescale 1ns/1ps

module resultCollector #(
    parameter int NumPixels  = 4,
    parameter int OutCredits = 2,
    localparam int PixWidth  = (NumPixels > 1) ? $clog2(NumPixels) : 1,
    localparam int CredWidth = $clog2(OutCredits + 1)
) (
    input  logic                            clk,
    input  logic                            combin_res,
    input  logic [NumPixels-1:0]            resValid,
    input  histPkg::binT   [NumPixels-1:0]  resCoarse,
    input  histPkg::sampleT [NumPixels-1:0] resFine,
    input  histPkg::countT [NumPixels-1:0]  resCount,
    output logic [NumPixels-1:0]            takeResult,
    output logic                            outValid,
    output logic [PixWidth-1:0]             outPixel,
    output histPkg::binT                    outCoarse,
    output histPkg::sampleT                 outFine,
    output histPkg::countT                  outCount,
    input  logic                            outCredit
);

    logic [PixWidth-1:0]  lastGrant;
    logic [PixWidth-1:0]  grantIdx;
    logic                 grantHit;
    logic [CredWidth-1:0] credits;      // downstream slots still free

    // round robin, search starts just after the last granted lane
    always_comb begin
        logic [PixWidth-1:0] probe;
        grantHit = 1'b0;
        grantIdx = lastGrant;
        for (int k = 1; k <= NumPixels; k++) begin
            probe = PixWidth'((int'(lastGrant) + k) % NumPixels);
            if (!grantHit && resValid[probe] && credits != '0) begin
                grantHit = 1'b1;
                grantIdx = probe;
            end
        end
    end

    always_comb begin
        takeResult = '0;
        if (grantHit) begin
            takeResult[grantIdx] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            lastGrant <= PixWidth'(NumPixels - 1);  // first search begins at lane 0
            credits   <= CredWidth'(OutCredits);
            outValid  <= 1'b0;
        end else begin
            outValid <= grantHit;
            if (grantHit) begin
                lastGrant <= grantIdx;
            end
            if (grantHit && !outCredit) begin
                credits <= credits - 1'b1;  // spent at grant time
            end else if (!grantHit && outCredit) begin
                credits <= credits + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantHit) begin
            outPixel  <= grantIdx;
            outCoarse <= resCoarse[grantIdx];
            outFine   <= resFine[grantIdx];
            outCount  <= resCount[grantIdx];
        end
    end

endmodule

/* hdl/histTop.sv */
`timescale 1ns/1ps

module histTop #(
    parameter int NumPixels      = 4,
    parameter int SamplesPerPass = 16,
    parameter int InDepth        = 4,
    parameter int LaneDepth      = 2,
    parameter int OutCredits     = 2,
    localparam int PixWidth = (NumPixels > 1) ? $clog2(NumPixels) : 1
) (
    input  logic                clk,
    input  logic                combin_res,
    // upstream sample port
    input  logic                inValid,
    input  logic [PixWidth-1:0] inPixel,
    input  histPkg::sampleT     inSample,
    output logic                inCredit,
    // downstream result port
    output logic                outValid,
    output logic [PixWidth-1:0] outPixel,
    output histPkg::binT        outCoarse,
    output histPkg::sampleT     outFine,
    output histPkg::countT      outCount,
    input  logic                outCredit
);

    import histPkg::*;

    logic [NumPixels-1:0]   laneValid;
    sampleT                 laneSample;     // shared by all lanes
    logic [NumPixels-1:0]   laneCredit;
    logic [NumPixels-1:0]   resValid;
    binT [NumPixels-1:0]    resCoarse;
    sampleT [NumPixels-1:0] resFine;
    countT [NumPixels-1:0]  resCount;
    logic [NumPixels-1:0]   takeResult;

    sampleDistributor #(
        .NumPixels (NumPixels),
        .InDepth   (InDepth),
        .LaneDepth (LaneDepth)
    ) distributor (
        .clk        (clk),
        .combin_res (combin_res),
        .inValid    (inValid),
        .inPixel    (inPixel),
        .inSample   (inSample),
        .inCredit   (inCredit),
        .laneValid  (laneValid),
        .laneSample (laneSample),
        .laneCredit (laneCredit)
    );

    for (genvar p = 0; p < NumPixels; p++) begin : laneGen
        histLane #(
            .SamplesPerPass (SamplesPerPass),
            .LaneDepth      (LaneDepth)
        ) lane (
            .clk        (clk),
            .combin_res (combin_res),
            .laneValid  (laneValid[p]),
            .laneSample (laneSample),
            .laneCredit (laneCredit[p]),
            .resValid   (resValid[p]),
            .resCoarse  (resCoarse[p]),
            .resFine    (resFine[p]),
            .resCount   (resCount[p]),
            .takeResult (takeResult[p])
        );
    end

    resultCollector #(
        .NumPixels  (NumPixels),
        .OutCredits (OutCredits)
    ) collector (
        .clk        (clk),
        .combin_res (combin_res),
        .resValid   (resValid),
        .resCoarse  (resCoarse),
        .resFine    (resFine),
        .resCount   (resCount),
        .takeResult (takeResult),
        .outValid   (outValid),
        .outPixel   (outPixel),
        .outCoarse  (outCoarse),
        .outFine    (outFine),
        .outCount   (outCount),
        .outCredit  (outCredit)
    );

endmodule

/* verification/histTb.sv */
`timescale 1ns/1ps

module histTb;

    import histPkg::*;

    localparam int NumPixels      = 4;      // matches the DUT defaults
    localparam int SamplesPerPass = 16;
    localparam int InDepth        = 4;
    localparam int OutCredits     = 2;
    localparam int PixWidth       = $clog2(NumPixels);
    localparam int NumRows        = 12;
    localparam int RowLen         = 2 * SamplesPerPass;
    localparam int TotalSamples   = NumRows * RowLen;
    localparam int LimitCycles    = TotalSamples * 40 + NumRows * BinCount;

    logic                clk;
    logic                combin_res;
    logic                inValid;
    logic [PixWidth-1:0] inPixel;
    sampleT              inSample;
    logic                inCredit;
    logic                outValid;
    logic [PixWidth-1:0] outPixel;
    binT                 outCoarse;
    sampleT              outFine;
    countT               outCount;
    logic                outCredit;

    // one acquisition per row, each group of four rows covers every pixel once
    // kinds: 0 cluster, 1 coarse tie, 2 fine mostly outside, 3 fine all outside
    // row 7 ties on bins that still hold row 3 fine counts unless the memory is cleared
    int rowPix  [NumRows] = '{0, 1, 2, 3, 0, 1, 2, 3, 0, 1, 2, 3};
    int rowLen  [NumRows] = '{default: RowLen};
    int rowBase [NumRows] = '{'h500, 'h003, 'hFF3, 'h700, 'h200, 'h9C0,
                              'h004, 'hA00, 'hA05, 'h650, 'hE00, 'h300};
    int rowKind [NumRows] = '{0, 0, 0, 1, 2, 3, 1, 1, 0, 2, 3, 1};

    int          sendPix  [TotalSamples];
    int          sendCode [TotalSamples];
    logic [23:0] expArr   [NumPixels][NumRows];   // {coarse, fine, count}
    int          writeCnt [NumPixels];
    int          readIdx  [NumPixels];
    int          sent;
    int          creditPulses;
    int          received;

    histTop uut (
        .clk        (clk),
        .combin_res (combin_res),
        .inValid    (inValid),
        .inPixel    (inPixel),
        .inSample   (inSample),
        .inCredit   (inCredit),
        .outValid   (outValid),
        .outPixel   (outPixel),
        .outCoarse  (outCoarse),
        .outFine    (outFine),
        .outCount   (outCount),
        .outCredit  (outCredit)
    );

    task automatic checkEq(input int got, input int want, input string what);
        if (got != want) begin
            $display("mismatch at time %0t: %s, got 0x%0h, expected 0x%0h",
                     $time, what, got, want);
            $display("test failed");
            $fatal(1);
        end
    endtask

    // timestamp idx of an acquisition, first half coarse pass, second half fine pass
    function automatic int sampleOf(input int base, input int kind, input int idx);
        int j;
        int code;
        j = idx - SamplesPerPass;
        if (idx < SamplesPerPass) begin
            code = base + (idx * 5) % 11;
            if (kind == 1 && idx % 2 == 1) begin
                code = code + 2 ** BinShift;    // neighbour bin, always one behind
            end
        end else if (kind == 2) begin
            code = base + j * 40;
        end else if (kind == 3) begin
            code = base + CodeTop / 2 + j;      // far from any window
        end else begin
            code = base + (j * 3) % 13;
        end
        return code % CodeTop;
    endfunction

    function automatic logic [23:0] expectedResult(input int base, input int kind);
        int cnt [BinCount];
        int maxC;
        int maxB;
        int coarseB;
        int code;
        int start;
        int b;
        maxC = 0;
        maxB = 0;
        foreach (cnt[i]) cnt[i] = 0;
        for (int i = 0; i < SamplesPerPass; i++) begin
            b = sampleOf(base, kind, i) >> BinShift;
            if (cnt[b] < 2 ** CountWidth - 1) cnt[b]++;
            if (cnt[b] > maxC) begin
                maxC = cnt[b];
                maxB = b;
            end
        end
        coarseB = maxB;
        code = coarseB * 2 ** BinShift;
        if (code <= HalfWindow) start = 0;
        else if (code >= CodeTop - HalfWindow) start = WindowTop;
        else start = code - HalfWindow;
        maxC = 0;
        maxB = 0;
        foreach (cnt[i]) cnt[i] = 0;
        for (int i = SamplesPerPass; i < 2 * SamplesPerPass; i++) begin
            b = sampleOf(base, kind, i) - start;    // window offset
            if (b >= 0 && b < BinCount) begin
                if (cnt[b] < 2 ** CountWidth - 1) cnt[b]++;
                if (cnt[b] > maxC) begin
                    maxC = cnt[b];
                    maxB = b;
                end
            end
        end
        return {binT'(coarseB), sampleT'(start + maxB), countT'(maxC)};
    endfunction

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (LimitCycles) @(posedge clk);
        $display("run did not finish: results still outstanding at the cycle limit");
        $display("test failed");
        $fatal(1);
    end

    // upstream credits come back in the cycle the distributor pops
    always @(negedge clk) begin
        if (combin_res && inCredit) begin
            creditPulses++;
            checkEq(int'(creditPulses <= sent), 1, "inCredit without a sample outstanding");
        end
    end

    initial begin
        int n;
        int r;
        void'($urandom(30));
        combin_res = 1'b0;
        inValid = 1'b0;
        inPixel = '0;
        inSample = '0;
        sent = 0;
        creditPulses = 0;
        foreach (writeCnt[p]) writeCnt[p] = 0;
        foreach (readIdx[p]) readIdx[p] = 0;
        for (int k = 0; k < NumRows; k++) begin
            expArr[rowPix[k]][writeCnt[rowPix[k]]] = expectedResult(rowBase[k], rowKind[k]);
            writeCnt[rowPix[k]]++;
        end
        n = 0;
        for (int g = 0; g < NumRows / NumPixels; g++) begin
            for (int idx = 0; idx < RowLen; idx++) begin
                for (int k = 0; k < NumPixels; k++) begin
                    r = g * NumPixels + k;
                    if (idx < rowLen[r]) begin
                        sendPix[n] = rowPix[r];
                        sendCode[n] = sampleOf(rowBase[r], rowKind[r], idx);
                        n++;
                    end
                end
            end
        end
        repeat (2) @(posedge clk);
        #1 combin_res = 1'b1;
        while (sent < TotalSamples) begin
            @(posedge clk);
            #1;
            if (sent - creditPulses < InDepth) begin   // a credit is held
                inValid = 1'b1;
                inPixel = PixWidth'(sendPix[sent]);
                inSample = sampleT'(sendCode[sent]);
                sent++;
            end else begin
                inValid = 1'b0;
            end
        end
        @(posedge clk);
        #1 inValid = 1'b0;
        wait (received == NumRows);
        repeat (4 * BinCount) @(posedge clk);           // room for a stray duplicate
        checkEq(creditPulses, TotalSamples, "inCredit pulse total");
        $display("test passed");
        $finish;
    end

    // sink, returns one credit per result after a random hold
    initial begin
        int holdLeft;
        int owed;
        int pulsesTotal;
        int prevTotal;
        int lagTotal;
        int pix;
        logic [23:0] exp;
        outCredit = 1'b0;
        holdLeft = 0;
        owed = 0;
        pulsesTotal = 0;
        prevTotal = 0;
        lagTotal = 0;
        received = 0;
        wait (combin_res === 1'b1);
        forever begin
            @(posedge clk);
            #1;
            if (owed > 0 && holdLeft == 0) begin
                outCredit = 1'b1;
                owed--;
                pulsesTotal++;
                holdLeft = int'($urandom % 12);
            end else begin
                outCredit = 1'b0;
                if (holdLeft > 0) holdLeft--;
            end
            @(negedge clk);
            if (outValid) begin
                received++;
                owed++;
                // grant one cycle ahead can only use credits returned before it
                checkEq(int'(received <= OutCredits + lagTotal), 1, "outValid without a credit");
                pix = int'(outPixel);
                checkEq(int'(readIdx[pix] < writeCnt[pix]), 1,
                        $sformatf("extra result for pixel %0d", pix));
                exp = expArr[pix][readIdx[pix]];
                readIdx[pix]++;
                checkEq(int'(outCoarse), int'(exp[23:20]), $sformatf("pixel %0d coarse", pix));
                checkEq(int'(outFine), int'(exp[19:8]), $sformatf("pixel %0d fine code", pix));
                checkEq(int'(outCount), int'(exp[7:0]), $sformatf("pixel %0d fine count", pix));
            end
            lagTotal = prevTotal;
            prevTotal = pulsesTotal;
        end
    end

endmodule

/* verilog.f */
common/histPkg.sv
hdl/sampleDistributor.sv
histLane/histLane.sv
hdl/resultCollector.sv
hdl/histTop.sv
verification/histTb.sv

/* Makefile */
# Verilator build and run of the histogram engine testbench

VERILATOR ?= verilator
TOP       ?= histTb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal
PASS_MSG  ?= test passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(OBJ_DIR)/V%: $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* -Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$($(abspath $(SIM)))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
